// ==== verilog/gb_pkg.sv ====
`default_nettype none

package gb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cpu address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [15:0] rom_end      = 16'h7fff;
	localparam logic [15:0] vid_base     = 16'h8000;
	localparam logic [15:0] cram_base    = 16'ha000;
	localparam logic [15:0] wram_base    = 16'hc000;
	// echo of work ram ends here
	localparam logic [15:0] echo_end     = 16'hfdff;
	localparam logic [15:0] oam_base     = 16'hfe00;
	localparam logic [15:0] oam_end      = 16'hfe9f;
	localparam logic [15:0] io_page_base = 16'hff00;
	localparam logic [15:0] hram_base    = 16'hff80;

	localparam int hram_depth = 127;

	// timer registers, low byte of the i/o address
	localparam logic [7:0] reg_div  = 8'h04;
	localparam logic [7:0] reg_tima = 8'h05;
	localparam logic [7:0] reg_tma  = 8'h06;
	localparam logic [7:0] reg_tac  = 8'h07;

	localparam logic [7:0] ram_enable_key = 8'h0a;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		tgt_none,
		tgt_timer,
		tgt_hram,
		tgt_ext,
		tgt_vid
	} bus_target_e;

	// tac[1:0] picks the divider tap
	typedef enum logic [1:0] {
		rate_bit9 = 2'd0,
		rate_bit3 = 2'd1,
		rate_bit5 = 2'd2,
		rate_bit7 = 2'd3
	} tim_rate_e;

	typedef enum logic {
		rom_banking = 1'b0,
		ram_banking = 1'b1
	} mbc_mode_e;

endpackage

`default_nettype wire

// ==== verilog/gb_memmap.sv ====
`default_nettype none

module gb_memmap (
	input  logic [15:0] adr,
	output logic        sel_rom,
	output logic        sel_vid,
	output logic        sel_cram,
	output logic        sel_wram,
	output logic        sel_io
);
	import gb_pkg::*;

	logic in_vram;
	logic in_oam;

	// cartridge rom fills the lower half
	assign sel_rom = adr <= rom_end;

	// vram and oam both go out on the video bus
	assign in_vram = (adr >= vid_base) && (adr < cram_base);
	assign in_oam  = (adr >= oam_base) && (adr <= oam_end);
	assign sel_vid = in_vram || in_oam;

	assign sel_cram = (adr >= cram_base) && (adr < wram_base);

	// includes the echo area up to 0xfdff
	assign sel_wram = (adr >= wram_base) && (adr <= echo_end);

	// 0xfea0..0xfeff selects nothing
	assign sel_io = adr >= io_page_base;

endmodule

`default_nettype wire

// ==== verilog/gb_iomap.sv ====
`default_nettype none

module gb_iomap (
	input  logic [7:0] adr,
	input  logic       io_sel,
	output logic       sel_tim,
	output logic       sel_hram
);
	import gb_pkg::*;

	logic [7:0] hram_ofs;

	// div, tima, tma and tac sit next to each other
	assign sel_tim = io_sel && (adr >= reg_div) && (adr <= reg_tac);

	// high ram stops one byte short of the page end, 0xffff stays unmapped
	assign hram_ofs = adr - hram_base[7:0];
	assign sel_hram = io_sel && (adr >= hram_base[7:0]) && (hram_ofs < 8'(hram_depth));

endmodule

`default_nettype wire

// ==== verilog/gb_timer.sv ====
`default_nettype none

module gb_timer (
	input  logic       gbclk,
	input  logic       reset,
	input  logic [1:0] adr,
	input  logic [7:0] wdata,
	input  logic       read,
	input  logic       write,
	output logic [7:0] rdata,
	output logic       irq
);
	import gb_pkg::*;

	logic [15:0] div;
	logic [7:0]  tima;
	logic [7:0]  tma;
	logic [2:0]  tac;
	tim_rate_e   rate;
	logic        tap;
	logic        tap_en;
	logic        tap_q;
	logic        tick;
	logic        wr_div;
	logic        wr_tima;
	logic        wr_tma;
	logic        wr_tac;

	assign wr_div  = write && (adr == reg_div[1:0]);
	assign wr_tima = write && (adr == reg_tima[1:0]);
	assign wr_tma  = write && (adr == reg_tma[1:0]);
	assign wr_tac  = write && (adr == reg_tac[1:0]);

	assign rate = tim_rate_e'(tac[1:0]);

	always_comb begin
		case (rate)
			rate_bit9: tap = div[9];
			rate_bit3: tap = div[3];
			rate_bit5: tap = div[5];
			rate_bit7: tap = div[7];
			default:   tap = div[9];
		endcase
	end

	// tima counts on the falling edge of the gated tap
	assign tap_en = tac[2] && tap;
	assign tick   = tap_q && !tap_en;

	always_ff @(posedge gbclk) begin
		if (reset) begin
			div   <= '0;
			tima  <= '0;
			tma   <= '0;
			tac   <= '0;
			tap_q <= 1'b0;
			irq   <= 1'b0;
		end else begin
			irq <= 1'b0;
			if (wr_div)
				div <= '0;
			else
				div <= div + 16'd1;
			// restart edge detect so a div or tac write gives no extra tick
			if (wr_div || wr_tac)
				tap_q <= 1'b0;
			else
				tap_q <= tap_en;
			if (wr_tima) begin
				tima <= wdata;
			end else if (tick) begin
				if (tima == 8'hff) begin
					tima <= tma;
					irq  <= 1'b1;
				end else begin
					tima <= tima + 8'd1;
				end
			end
			if (wr_tma)
				tma <= wdata;
			if (wr_tac)
				tac <= wdata[2:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge gbclk) begin
		if (read) begin
			case (adr)
				reg_div[1:0]:  rdata <= div[15:8];
				reg_tima[1:0]: rdata <= tima;
				reg_tma[1:0]:  rdata <= tma;
				default:       rdata <= {5'b11111, tac};
			endcase
		end
	end

	a_rd_wr_excl: assert property (@(posedge gbclk) disable iff (reset) !(read && write));

endmodule

`default_nettype wire

// ==== verilog/gb_hram.sv ====
`default_nettype none

module gb_hram (
	input  logic       gbclk,
	input  logic [6:0] adr,
	input  logic [7:0] wdata,
	input  logic       read,
	input  logic       write,
	output logic [7:0] rdata
);
	import gb_pkg::*;

	logic [7:0] mem [hram_depth];

	always_ff @(posedge gbclk) begin
		if (write)
			mem[adr] <= wdata;
	end

	// read data lands at the read edge
	always_ff @(posedge gbclk) begin
		if (read)
			rdata <= mem[adr];
	end

endmodule

`default_nettype wire

// ==== verilog/gb_mbc.sv ====
`default_nettype none

module gb_mbc (
	input  logic        gbclk,
	input  logic        reset,
	input  logic [15:0] adr,
	input  logic [7:0]  wdata,
	input  logic        write,
	input  logic        sel_rom,
	input  logic        sel_cram,
	output logic [20:0] ext_adr,
	output logic        cs_crom,
	output logic        cs_cram
);
	import gb_pkg::*;

	logic      ram_en;
	logic [4:0] rom_bank;
	logic [1:0] upper_bank;
	mbc_mode_e  mode;
	logic [1:0] low_bank;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bank registers, written through the rom space
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge gbclk) begin
		if (reset) begin
			ram_en     <= 1'b0;
			rom_bank   <= 5'd1;
			upper_bank <= 2'd0;
			mode       <= rom_banking;
		end else if (write && sel_rom) begin
			case (adr[14:13])
				2'd0: ram_en <= wdata == ram_enable_key;
				// bank 0 is not reachable in the switchable window
				2'd1: rom_bank <= (wdata[4:0] == 5'd0) ? 5'd1 : wdata[4:0];
				2'd2: upper_bank <= wdata[1:0];
				default: mode <= mbc_mode_e'(wdata[0]);
			endcase
		end
	end

	// upper bits only reach the fixed window and cram in ram banking mode
	assign low_bank = (mode == ram_banking) ? upper_bank : 2'd0;

	always_comb begin
		if (sel_rom && !adr[14])
			ext_adr = {low_bank, 5'd0, adr[13:0]};
		else if (sel_rom)
			ext_adr = {upper_bank, rom_bank, adr[13:0]};
		else if (sel_cram)
			ext_adr = {6'd0, low_bank, adr[12:0]};
		else
			ext_adr = '0;
	end

	assign cs_crom = sel_rom;
	assign cs_cram = sel_cram && ram_en;

endmodule

`default_nettype wire

// ==== verilog/gb_bus_top.sv ====
`default_nettype none

module gb_bus_top (
	input  logic        gbclk,
	input  logic        reset,
	input  logic [15:0] adr,
	input  logic [7:0]  wdata,
	input  logic        read,
	input  logic        write,
	input  logic [7:0]  ext_rdata,
	input  logic [7:0]  vid_rdata,
	output logic [7:0]  rdata,
	output logic        irq_timer,
	output logic [20:0] ext_adr,
	output logic        ext_read,
	output logic        ext_write,
	output logic        cs_ram,
	output logic        cs_crom,
	output logic        cs_cram,
	output logic        vid_read,
	output logic        vid_write
);
	import gb_pkg::*;

	logic        access;
	logic        sel_rom;
	logic        sel_vid;
	logic        sel_cram;
	logic        sel_wram;
	logic        sel_io;
	logic        sel_tim;
	logic        sel_hram;
	logic        ext_sel;
	logic [20:0] mbc_adr;
	logic [7:0]  tim_rdata;
	logic [7:0]  hram_rdata;
	logic [7:0]  ext_q;
	logic [7:0]  vid_q;
	bus_target_e target;
	bus_target_e rd_target;

	// selects stay low on idle cycles
	assign access = read || write;

	gb_memmap u_memmap (
		.adr      (adr),
		.sel_rom  (sel_rom),
		.sel_vid  (sel_vid),
		.sel_cram (sel_cram),
		.sel_wram (sel_wram),
		.sel_io   (sel_io)
	);

	gb_iomap u_iomap (
		.adr      (adr[7:0]),
		.io_sel   (sel_io),
		.sel_tim  (sel_tim),
		.sel_hram (sel_hram)
	);

	gb_timer u_timer (
		.gbclk (gbclk),
		.reset (reset),
		.adr   (adr[1:0]),
		.wdata (wdata),
		.read  (read && sel_tim),
		.write (write && sel_tim),
		.rdata (tim_rdata),
		.irq   (irq_timer)
	);

	gb_hram u_hram (
		.gbclk (gbclk),
		.adr   (adr[6:0]),
		.wdata (wdata),
		.read  (read && sel_hram),
		.write (write && sel_hram),
		.rdata (hram_rdata)
	);

	gb_mbc u_mbc (
		.gbclk    (gbclk),
		.reset    (reset),
		.adr      (adr),
		.wdata    (wdata),
		.write    (write),
		.sel_rom  (sel_rom && access),
		.sel_cram (sel_cram && access),
		.ext_adr  (mbc_adr),
		.cs_crom  (cs_crom),
		.cs_cram  (cs_cram)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// external and video strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign cs_ram  = sel_wram && access;
	assign ext_sel = cs_crom || cs_cram || cs_ram;

	// echo area folds onto work ram by dropping bit 13
	assign ext_adr = cs_ram ? {5'd0, adr[15:14], 1'b0, adr[12:0]} : mbc_adr;

	assign ext_read  = read && ext_sel;
	// rom writes only program the mbc
	assign ext_write = write && ext_sel && !cs_crom;

	assign vid_read  = read && sel_vid;
	assign vid_write = write && sel_vid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered read path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		if (sel_tim)
			target = tgt_timer;
		else if (sel_hram)
			target = tgt_hram;
		else if (ext_sel)
			target = tgt_ext;
		else if (sel_vid)
			target = tgt_vid;
		else
			target = tgt_none;
	end

	always_ff @(posedge gbclk) begin
		if (reset)
			rd_target <= tgt_none;
		else if (read)
			rd_target <= target;
	end

	always_ff @(posedge gbclk) begin
		if (ext_read)
			ext_q <= ext_rdata;
		if (vid_read)
			vid_q <= vid_rdata;
	end

	always_comb begin
		case (rd_target)
			tgt_timer: rdata = tim_rdata;
			tgt_hram:  rdata = hram_rdata;
			tgt_ext:   rdata = ext_q;
			tgt_vid:   rdata = vid_q;
			default:   rdata = 8'hff;
		endcase
	end

	a_cpu_rd_wr: assert property (@(posedge gbclk) disable iff (reset) !(read && write));

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic gbclk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 20;
	localparam int reset_cycles = 16;

	initial begin
		gbclk = 1'b0;
		forever #half_period gbclk = ~gbclk;
	end

	// release reset away from the rising edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge gbclk);
		@(negedge gbclk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/tb_gb_bus.sv ====
`default_nettype none

module tb_gb_bus;
	timeunit 1ns;
	timeprecision 100ps;
	import gb_pkg::*;

	// about four times the cycles that the tests below take
	localparam int watchdog_cycles = 6000;
	localparam int div_wait = 600;

	logic        gbclk;
	logic        reset;
	logic [15:0] adr;
	logic [7:0]  wdata;
	logic        read;
	logic        write;
	logic [7:0]  ext_rdata;
	logic [7:0]  vid_rdata;
	logic [7:0]  rdata;
	logic        irq_timer;
	logic [20:0] ext_adr;
	logic        ext_read;
	logic        ext_write;
	logic        cs_ram;
	logic        cs_crom;
	logic        cs_cram;
	logic        vid_read;
	logic        vid_write;

	// strobes seen in the middle of the last access
	logic [20:0] snap_ext_adr;
	logic        snap_ext_read;
	logic        snap_ext_write;
	logic        snap_cs_ram;
	logic        snap_cs_crom;
	logic        snap_cs_cram;
	logic        snap_vid_read;
	logic        snap_vid_write;

	logic [7:0]  ext_mem [2**21];
	logic [7:0]  vid_mem [2**16];
	logic [7:0]  irq_count;
	integer      seed = 32'heb3553b5;

	tb_clock u_clock (
		.gbclk (gbclk),
		.reset (reset)
	);

	gb_bus_top u_dut (
		.gbclk     (gbclk),
		.reset     (reset),
		.adr       (adr),
		.wdata     (wdata),
		.read      (read),
		.write     (write),
		.ext_rdata (ext_rdata),
		.vid_rdata (vid_rdata),
		.rdata     (rdata),
		.irq_timer (irq_timer),
		.ext_adr   (ext_adr),
		.ext_read  (ext_read),
		.ext_write (ext_write),
		.cs_ram    (cs_ram),
		.cs_crom   (cs_crom),
		.cs_cram   (cs_cram),
		.vid_read  (vid_read),
		.vid_write (vid_write)
	);

	// memory models answer combinationally while strobed
	assign ext_rdata = ext_read ? ext_mem[ext_adr] : 8'h00;
	assign vid_rdata = vid_read ? vid_mem[adr] : 8'h00;

	always @(negedge gbclk) begin
		if (reset)
			irq_count <= 8'd0;
		else if (irq_timer)
			irq_count <= irq_count + 8'd1;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge gbclk);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic verify_addr(input string name, input logic [20:0] got, input logic [20:0] exp);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cpu side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic fill_memories();
		logic [21:0] a;
		for (a = 22'd0; a < 22'h200000; a = a + 22'd1)
			ext_mem[a[20:0]] = a[7:0] ^ {a[12:8], a[15:13]} ^ {3'b101, a[20:16]};
		for (a = 22'd0; a < 22'h010000; a = a + 22'd1)
			vid_mem[a[15:0]] = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
	endtask

	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d,
		input logic rd, input logic wr);
		@(negedge gbclk);
		adr   = a;
		wdata = d;
		read  = rd;
		write = wr;
		#5;
		snap_ext_adr   = ext_adr;
		snap_ext_read  = ext_read;
		snap_ext_write = ext_write;
		snap_cs_ram    = cs_ram;
		snap_cs_crom   = cs_crom;
		snap_cs_cram   = cs_cram;
		snap_vid_read  = vid_read;
		snap_vid_write = vid_write;
		// external memories take the write at the rising edge
		@(posedge gbclk);
		if (snap_ext_write)
			ext_mem[snap_ext_adr] = wdata;
		if (snap_vid_write)
			vid_mem[adr] = wdata;
		@(negedge gbclk);
		read  = 1'b0;
		write = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(a, d, 1'b0, 1'b1);
	endtask

	// rdata is taken one cycle after the read edge
	task automatic cpu_read(input logic [15:0] a, output logic [7:0] d);
		bus_cycle(a, 8'h00, 1'b1, 1'b0);
		d = rdata;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic hram_fill_and_readback();
		logic [7:0] shadow [hram_depth];
		logic [7:0] rd;
		logic [6:0] ofs;
		logic [31:0] rnd;
		for (int i = 0; i < hram_depth; i++) begin
			rnd = $random(seed);
			ofs = 7'(i);
			shadow[ofs] = rnd[7:0];
			cpu_write(hram_base + 16'(ofs), rnd[7:0]);
		end
		// overwrite at random offsets
		for (int k = 0; k < 64; k++) begin
			rnd = $random(seed);
			ofs = (rnd[6:0] == 7'h7f) ? 7'h00 : rnd[6:0];
			shadow[ofs] = rnd[15:8];
			cpu_write(hram_base + 16'(ofs), rnd[15:8]);
		end
		for (int i = 0; i < hram_depth; i++) begin
			ofs = 7'(i);
			cpu_read(hram_base + 16'(ofs), rd);
			compare_byte("rdata hram", rd, shadow[ofs]);
		end
	endtask

	task automatic address_decode();
		logic [7:0] rd;
		cpu_read(16'hff10, rd);
		compare_byte("rdata io gap", rd, 8'hff);
		cpu_read(16'hffff, rd);
		compare_byte("rdata ffff", rd, 8'hff);
		cpu_read(16'hfea0, rd);
		compare_byte("rdata fea0", rd, 8'hff);
		expect_flag("ext_read", snap_ext_read, 1'b0);
		expect_flag("vid_read", snap_vid_read, 1'b0);
		cpu_read(16'h8123, rd);
		expect_flag("vid_read", snap_vid_read, 1'b1);
		compare_byte("rdata vram", rd, vid_mem[16'h8123]);
		cpu_write(16'hfe10, 8'h77);
		expect_flag("vid_write", snap_vid_write, 1'b1);
		cpu_read(16'hfe10, rd);
		compare_byte("rdata oam", rd, 8'h77);
		cpu_read(16'hc123, rd);
		expect_flag("cs_ram", snap_cs_ram, 1'b1);
		verify_addr("ext_adr wram", snap_ext_adr, 21'h0c123);
		compare_byte("rdata wram", rd, ext_mem[21'h0c123]);
		// echo region folds onto the same byte
		cpu_read(16'he123, rd);
		expect_flag("cs_ram", snap_cs_ram, 1'b1);
		verify_addr("ext_adr echo", snap_ext_adr, 21'h0c123);
		compare_byte("rdata echo", rd, ext_mem[21'h0c123]);
	endtask

	task automatic rom_bank_switch();
		logic [7:0] rd;
		cpu_write(16'h2000, 8'h00);
		expect_flag("cs_crom", snap_cs_crom, 1'b1);
		expect_flag("ext_write", snap_ext_write, 1'b0);
		cpu_read(16'h4000, rd);
		expect_flag("cs_crom", snap_cs_crom, 1'b1);
		verify_addr("ext_adr bank 0", snap_ext_adr, 21'h04000);
		compare_byte("rdata bank 0", rd, ext_mem[21'h04000]);
		cpu_write(16'h2000, 8'h05);
		cpu_read(16'h4123, rd);
		verify_addr("ext_adr bank 5", snap_ext_adr, 21'h14123);
		compare_byte("rdata bank 5", rd, ext_mem[21'h14123]);
		cpu_write(16'h2000, 8'h1f);
		cpu_write(16'h4000, 8'h02);
		cpu_read(16'h7fff, rd);
		verify_addr("ext_adr bank 5f", snap_ext_adr, 21'h17ffff);
		compare_byte("rdata bank 5f", rd, ext_mem[21'h17ffff]);
		// fixed window stays on bank 0 in rom banking mode
		cpu_read(16'h0100, rd);
		verify_addr("ext_adr fixed", snap_ext_adr, 21'h00100);
	endtask

	task automatic cart_ram_access();
		logic [7:0] rd;
		cpu_read(16'ha010, rd);
		expect_flag("cs_cram", snap_cs_cram, 1'b0);
		expect_flag("ext_read", snap_ext_read, 1'b0);
		compare_byte("rdata cram off", rd, 8'hff);
		cpu_write(16'h0000, ram_enable_key);
		cpu_write(16'h6000, 8'h01);
		cpu_write(16'h4000, 8'h03);
		cpu_read(16'ha010, rd);
		expect_flag("cs_cram", snap_cs_cram, 1'b1);
		verify_addr("ext_adr cram", snap_ext_adr, 21'h06010);
		compare_byte("rdata cram", rd, ext_mem[21'h06010]);
		cpu_write(16'ha020, 8'h5a);
		expect_flag("ext_write", snap_ext_write, 1'b1);
		cpu_read(16'ha020, rd);
		compare_byte("rdata cram write", rd, 8'h5a);
	endtask

	task automatic timer_overflow();
		logic [7:0] rd;
		logic [7:0] irq_start;
		// clear div first so no tick lands between the register writes
		cpu_write({io_page_base[15:8], reg_div}, 8'h00);
		cpu_write({io_page_base[15:8], reg_tma}, 8'h80);
		cpu_write({io_page_base[15:8], reg_tac}, 8'h05);
		cpu_write({io_page_base[15:8], reg_tima}, 8'hfe);
		irq_start = irq_count;
		cpu_write({io_page_base[15:8], reg_div}, 8'h00);
		// bit 3 falls 16 and 32 cycles after the clear, irq one cycle later
		repeat (34) @(negedge gbclk);
		compare_byte("irq_timer pulses", irq_count - irq_start, 8'd1);
		cpu_read({io_page_base[15:8], reg_tima}, rd);
		compare_byte("tima", rd, 8'h80);
		cpu_read({io_page_base[15:8], reg_tac}, rd);
		compare_byte("tac", rd, 8'hfd);
		cpu_write({io_page_base[15:8], reg_div}, 8'h00);
		repeat (div_wait) @(negedge gbclk);
		cpu_read({io_page_base[15:8], reg_div}, rd);
		// div counts every cycle from the clearing edge up to the read edge
		compare_byte("div", rd, 8'((div_wait + 1) >> 8));
	endtask

	initial begin
		adr   = 16'h0000;
		wdata = 8'h00;
		read  = 1'b0;
		write = 1'b0;
		fill_memories();
		@(negedge gbclk);
		while (reset)
			@(negedge gbclk);
		compare_byte("rdata after reset", rdata, 8'hff);
		expect_flag("irq_timer", irq_timer, 1'b0);
		expect_flag("strobes after reset",
			ext_read | ext_write | vid_read | vid_write | cs_ram | cs_crom | cs_cram, 1'b0);
		hram_fill_and_readback();
		address_decode();
		rom_bank_switch();
		cart_ram_access();
		timer_overflow();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/gb_pkg.sv
verilog/gb_memmap.sv
verilog/gb_iomap.sv
verilog/gb_timer.sv
verilog/gb_hram.sv
verilog/gb_mbc.sv
verilog/gb_bus_top.sv
sim/tb_clock.sv
sim/tb_gb_bus.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_gb_bus -o tb_gb_bus

./obj_dir/tb_gb_bus | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
